/* Bender.yml */
package:
  name: mesh_router

export_include_dirs:
  - hw

sources:
  - hw/router_pkg.sv
  - hw/flit_queue.sv
  - hw/route_comp.sv
  - hw/switch_alloc.sv
  - hw/output_stage.sv
  - hw/mesh_router.sv
  - target: test
    files:
      - verification/router_checker.sv
      - verification/tb_mesh_router.sv

/* all.f */
+incdir+hw
hw/router_pkg.sv
hw/flit_queue.sv
hw/route_comp.sv
hw/switch_alloc.sv
hw/output_stage.sv
hw/mesh_router.sv
verification/router_checker.sv
verification/tb_mesh_router.sv

/* hw/flit_queue.sv */
`include "router_consts.svh"

module flit_queue
    import router_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  link_t wr,
    input  logic  pop,
    output link_t head,
    output logic  full
);

    localparam int DEPTH = `ROUTER_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    flit_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // writes into a full queue are lost
    assign full  = (count == CNT_W'(DEPTH));
    assign do_wr = wr.valid && !full;
    assign do_rd = pop && (count != '0);

    assign head.valid = (count != '0);
    assign head.flit  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr.flit;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // simultaneous push and pop leaves count alone
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hw/mesh_router.sv */
`include "router_consts.svh"

module mesh_router
    import router_pkg::*;
#(
    parameter int cur_x = 0,
    parameter int cur_y = 0
) (
    input  logic  clk,
    input  logic  arst_n,
    input  link_t link_in [`ROUTER_NUM_PORTS],
    input  link_t inject [`ROUTER_NUM_PORTS],
    output link_t link_out [`ROUTER_NUM_PORTS],
    output link_t eject [`ROUTER_NUM_PORTS]
);

    localparam int NP = `ROUTER_NUM_PORTS;

    link_t         head [NP];
    route_t        route [NP];
    logic [NP-1:0] pop;
    logic [NP-1:0] inject_valid;
    logic [NP-1:0] grant_valid;
    port_idx_t     grant_src [NP];
    logic [NP-1:0] eject_sel;

    //////////////////////////////////////////////////
    // per input port: queue and route

    for (genvar i = 0; i < NP; i++) begin : g_port
        flit_queue u_flit_queue (
            .clk    (clk),
            .arst_n (arst_n),
            .wr     (link_in[i]),
            .pop    (pop[i]),
            .head   (head[i]),
            .full   ()
        );

        route_comp #(
            .cur_x (cur_x),
            .cur_y (cur_y)
        ) u_route_comp (
            .head  (head[i]),
            .route (route[i])
        );

        assign inject_valid[i] = inject[i].valid;
    end

    //////////////////////////////////////////////////
    // allocation and switch traversal

    switch_alloc u_switch_alloc (
        .clk          (clk),
        .arst_n       (arst_n),
        .route        (route),
        .inject_valid (inject_valid),
        .pop          (pop),
        .grant_valid  (grant_valid),
        .grant_src    (grant_src),
        .eject_sel    (eject_sel)
    );

    output_stage u_output_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .head        (head),
        .grant_valid (grant_valid),
        .grant_src   (grant_src),
        .eject_sel   (eject_sel),
        .inject      (inject),
        .link_out    (link_out),
        .eject       (eject)
    );

endmodule

/* hw/output_stage.sv */
`include "router_consts.svh"

module output_stage
    import router_pkg::*;
(
    input  logic                          clk,
    input  logic                          arst_n,
    input  link_t                         head [`ROUTER_NUM_PORTS],
    input  logic [`ROUTER_NUM_PORTS-1:0]  grant_valid,
    input  port_idx_t                     grant_src [`ROUTER_NUM_PORTS],
    input  logic [`ROUTER_NUM_PORTS-1:0]  eject_sel,
    input  link_t                         inject [`ROUTER_NUM_PORTS],
    output link_t                         link_out [`ROUTER_NUM_PORTS],
    output link_t                         eject [`ROUTER_NUM_PORTS]
);

    localparam int NP = `ROUTER_NUM_PORTS;

    link_t         out_next [NP];
    logic [NP-1:0] out_valid_q;
    flit_t         out_flit_q [NP];
    logic [NP-1:0] ej_valid_q;
    flit_t         ej_flit_q [NP];

    //////////////////////////////////////////////////
    // crossbar with inject override

    always_comb begin
        for (int o = 0; o < NP; o++) begin
            if (inject[o].valid) begin
                out_next[o] = inject[o];
            end else begin
                out_next[o].valid = grant_valid[o];
                out_next[o].flit  = head[grant_src[o]].flit;
            end
        end
    end

    //////////////////////////////////////////////////
    // output registers

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid_q <= '0;
            ej_valid_q  <= '0;
        end else begin
            for (int o = 0; o < NP; o++) begin
                out_valid_q[o] <= out_next[o].valid;
            end
            ej_valid_q <= eject_sel;
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < NP; o++) begin
            if (out_next[o].valid) begin
                out_flit_q[o] <= out_next[o].flit;
            end
            // eject port i carries the head of input i
            if (eject_sel[o]) begin
                ej_flit_q[o] <= head[o].flit;
            end
        end
    end

    always_comb begin
        for (int o = 0; o < NP; o++) begin
            link_out[o] = '{valid: out_valid_q[o], flit: out_flit_q[o]};
            eject[o]    = '{valid: ej_valid_q[o], flit: ej_flit_q[o]};
        end
    end

endmodule

/* hw/route_comp.sv */
`include "router_consts.svh"

module route_comp
    import router_pkg::*;
#(
    parameter int cur_x = 0,
    parameter int cur_y = 0
) (
    input  link_t  head,
    output route_t route
);

    localparam logic [`ROUTER_COORD_W-1:0] my_x = `ROUTER_COORD_W'(cur_x);
    localparam logic [`ROUTER_COORD_W-1:0] my_y = `ROUTER_COORD_W'(cur_y);

    // dimension order, x resolved before y
    always_comb begin
        route.valid = head.valid;
        route.eject = 1'b0;
        route.port  = PORT_XPOS;
        if (head.flit.dst_x > my_x) begin
            route.port = PORT_XPOS;
        end else if (head.flit.dst_x < my_x) begin
            route.port = PORT_XNEG;
        end else if (head.flit.dst_y > my_y) begin
            route.port = PORT_YPOS;
        end else if (head.flit.dst_y < my_y) begin
            route.port = PORT_YNEG;
        end else begin
            // arrived, leaves on the eject of its input port
            route.eject = 1'b1;
        end
    end

endmodule

/* hw/router_consts.svh */
`ifndef ROUTER_CONSTS_SVH
`define ROUTER_CONSTS_SVH

// one mesh axis
`define ROUTER_COORD_W 3

// sender tag, carried through untouched
`define ROUTER_TAG_W 8

`define ROUTER_PAYLOAD_W 32

// entries per input queue
`define ROUTER_QUEUE_DEPTH 8

// xpos, ypos, xneg, yneg
`define ROUTER_NUM_PORTS 4

`endif

/* hw/router_pkg.sv */
`include "router_consts.svh"

package router_pkg;

    // port order matches the link arrays
    typedef enum logic [1:0] {
        PORT_XPOS = 2'd0,
        PORT_YPOS = 2'd1,
        PORT_XNEG = 2'd2,
        PORT_YNEG = 2'd3
    } port_idx_t;

    typedef struct packed {
        logic [`ROUTER_COORD_W-1:0]   dst_x;
        logic [`ROUTER_COORD_W-1:0]   dst_y;
        logic [`ROUTER_COORD_W-1:0]   src_x;
        logic [`ROUTER_COORD_W-1:0]   src_y;
        logic [`ROUTER_TAG_W-1:0]     tag;
        logic [`ROUTER_PAYLOAD_W-1:0] payload;
    } flit_t;

    // bundle on every link, inject and eject port
    typedef struct packed {
        logic  valid;
        flit_t flit;
    } link_t;

    // port is don't care when eject is set
    typedef struct packed {
        logic      valid;
        logic      eject;
        port_idx_t port;
    } route_t;

endpackage

/* hw/switch_alloc.sv */
`include "router_consts.svh"

module switch_alloc
    import router_pkg::*;
(
    input  logic                          clk,
    input  logic                          arst_n,
    input  route_t                        route [`ROUTER_NUM_PORTS],
    input  logic [`ROUTER_NUM_PORTS-1:0]  inject_valid,
    output logic [`ROUTER_NUM_PORTS-1:0]  pop,
    output logic [`ROUTER_NUM_PORTS-1:0]  grant_valid,
    output port_idx_t                     grant_src [`ROUTER_NUM_PORTS],
    output logic [`ROUTER_NUM_PORTS-1:0]  eject_sel
);

    localparam int NP = `ROUTER_NUM_PORTS;

    port_idx_t     ptr [NP];
    logic [NP-1:0] req [NP];
    logic [NP-1:0] won;

    //////////////////////////////////////////////////
    // requests, indexed [output][input]

    always_comb begin
        for (int o = 0; o < NP; o++) begin
            for (int i = 0; i < NP; i++) begin
                req[o][i] = route[i].valid && !route[i].eject &&
                            (route[i].port == port_idx_t'(o));
            end
        end
    end

    //////////////////////////////////////////////////
    // round robin per output

    always_comb begin
        logic [1:0] sum;
        port_idx_t  cand;
        won = '0;
        for (int o = 0; o < NP; o++) begin
            grant_valid[o] = 1'b0;
            grant_src[o]   = PORT_XPOS;
            // walk down so the lowest offset from ptr wins
            for (int k = NP - 1; k >= 0; k--) begin
                sum  = ptr[o] + 2'(k);
                cand = port_idx_t'(sum);
                if (req[o][cand] && !inject_valid[o]) begin
                    grant_valid[o] = 1'b1;
                    grant_src[o]   = cand;
                end
            end
            if (grant_valid[o]) begin
                won[grant_src[o]] = 1'b1;
            end
        end
    end

    // ejecting heads never contend
    always_comb begin
        for (int i = 0; i < NP; i++) begin
            eject_sel[i] = route[i].valid && route[i].eject;
        end
    end

    assign pop = won | eject_sel;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int o = 0; o < NP; o++) begin
                ptr[o] <= PORT_XPOS;
            end
        end else begin
            for (int o = 0; o < NP; o++) begin
                if (grant_valid[o]) begin
                    ptr[o] <= port_idx_t'(2'(grant_src[o] + 1));
                end
            end
        end
    end

endmodule

/* verification/router_checker.sv */
`include "router_consts.svh"

module router_checker
    import router_pkg::*;
#(
    parameter int cur_x = 0,
    parameter int cur_y = 0
) (
    input  logic      clk,
    input  logic      arst_n,
    input  link_t     link_in [`ROUTER_NUM_PORTS],
    input  link_t     inject [`ROUTER_NUM_PORTS],
    input  link_t     link_out [`ROUTER_NUM_PORTS],
    input  link_t     eject [`ROUTER_NUM_PORTS],
    output int        err_count,
    output int        pending,
    output int        delivered,
    output port_idx_t last_src
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NP = `ROUTER_NUM_PORTS;
    localparam int NT = 1 << `ROUTER_TAG_W;

    // slots 0..3 are link_out, 4..7 are eject
    flit_t     exp_flit [2*NP][NT];
    bit        exp_live [2*NP][NT];
    bit        exp_inj  [2*NP][NT];
    int        exp_cyc  [2*NP][NT];
    port_idx_t exp_src  [2*NP][NT];

    int        cyc;
    int        errs;
    int        npend;
    int        ndeliv;
    port_idx_t last;

    // x first, then y, else eject on the arrival port
    function automatic int ref_port(input int in_port, input flit_t f);
        int dx;
        int dy;
        dx = int'(f.dst_x);
        dy = int'(f.dst_y);
        if (dx > cur_x) begin
            return 0;
        end else if (dx < cur_x) begin
            return 2;
        end else if (dy > cur_y) begin
            return 1;
        end else if (dy < cur_y) begin
            return 3;
        end
        return NP + in_port;
    endfunction

    function automatic string port_name(input int p);
        if (p < NP) begin
            return $sformatf("link_out[%0d]", p);
        end
        return $sformatf("eject[%0d]", p - NP);
    endfunction

    task automatic record(input int port, input int src, input bit inj, input flit_t f);
        int t;
        t = int'(f.tag);
        if (exp_live[port][t]) begin
            $display("tag %0d was sent again while still in flight at %0t", t, $time);
            errs++;
        end else begin
            npend++;
        end
        exp_live[port][t] = 1'b1;
        exp_flit[port][t] = f;
        exp_inj[port][t]  = inj;
        exp_cyc[port][t]  = cyc;
        exp_src[port][t]  = port_idx_t'(src);
    endtask

    task automatic check_out(input int port, input flit_t f);
        int t;
        int other;
        t     = int'(f.tag);
        other = -1;
        if (exp_live[port][t]) begin
            if (f != exp_flit[port][t]) begin
                $display("[FAIL] t=%0t: tag %0d on %s has wrong contents", $time, t,
                         port_name(port));
                errs++;
            end else if (exp_inj[port][t] && (cyc - exp_cyc[port][t] != 1)) begin
                $display("[FAIL] t=%0t: injected tag %0d took %0d cycles", $time, t,
                         cyc - exp_cyc[port][t]);
                errs++;
            end else if (!exp_inj[port][t] && (cyc - exp_cyc[port][t] < 2)) begin
                $display("[FAIL] t=%0t: tag %0d arrived after only %0d cycles", $time, t,
                         cyc - exp_cyc[port][t]);
                errs++;
            end
            ndeliv++;
            last = exp_src[port][t];
            exp_live[port][t] = 1'b0;
            npend--;
        end else begin
            for (int p = 0; p < 2*NP; p++) begin
                if (exp_live[p][t]) begin
                    other = p;
                end
            end
            if (other >= 0) begin
                $display("[FAIL] t=%0t: tag %0d on %s, expected on %s", $time, t,
                         port_name(port), port_name(other));
                exp_live[other][t] = 1'b0;
                npend--;
            end else begin
                $display("[FAIL] t=%0t: unexpected tag %0d on %s", $time, t, port_name(port));
            end
            errs++;
        end
    endtask

    //////////////////////////////////////////////////
    // scoreboard and compare

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int p = 0; p < 2*NP; p++) begin
                for (int t = 0; t < NT; t++) begin
                    exp_live[p][t] = 1'b0;
                end
            end
            cyc    = 0;
            errs   = 0;
            npend  = 0;
            ndeliv = 0;
            last   = PORT_XPOS;
        end else begin
            cyc++;
            // new flits first, a flit never leaves in the cycle it enters
            for (int i = 0; i < NP; i++) begin
                if (link_in[i].valid) begin
                    record(ref_port(i, link_in[i].flit), i, 1'b0, link_in[i].flit);
                end
                if (inject[i].valid) begin
                    record(i, i, 1'b1, inject[i].flit);
                end
            end
            for (int o = 0; o < NP; o++) begin
                if (link_out[o].valid) begin
                    check_out(o, link_out[o].flit);
                end
                if (eject[o].valid) begin
                    check_out(NP + o, eject[o].flit);
                end
            end
        end
        err_count <= errs;
        pending   <= npend;
        delivered <= ndeliv;
        last_src  <= last;
    end

endmodule

/* verification/tb_mesh_router.sv */
`include "router_consts.svh"

module tb_mesh_router
    import router_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NP          = `ROUTER_NUM_PORTS;
    localparam int CUR_X       = 3;
    localparam int CUR_Y       = 3;
    localparam int DRAIN_LIMIT = 300;

    logic      clk;
    logic      arst_n;
    link_t     link_in [NP];
    link_t     inject [NP];
    link_t     link_out [NP];
    link_t     eject [NP];
    link_t     stage_in [NP];
    link_t     stage_inj [NP];

    int        err_count;
    int        pending;
    int        delivered;
    port_idx_t last_src;

    integer    seed;
    int        next_tag;
    int        sent;
    int        tb_errs;
    bit        timed_out;

    // xpos, xneg, ypos, yneg, local
    int        dest_x [5] = '{5, 1, 3, 3, 3};
    int        dest_y [5] = '{3, 3, 6, 0, 3};

    initial clk = 1'b0;
    always #5 clk = ~clk;

    mesh_router #(
        .cur_x (CUR_X),
        .cur_y (CUR_Y)
    ) u_mesh_router (
        .clk      (clk),
        .arst_n   (arst_n),
        .link_in  (link_in),
        .inject   (inject),
        .link_out (link_out),
        .eject    (eject)
    );

    router_checker #(
        .cur_x (CUR_X),
        .cur_y (CUR_Y)
    ) u_router_checker (
        .clk       (clk),
        .arst_n    (arst_n),
        .link_in   (link_in),
        .inject    (inject),
        .link_out  (link_out),
        .eject     (eject),
        .err_count (err_count),
        .pending   (pending),
        .delivered (delivered),
        .last_src  (last_src)
    );

    //////////////////////////////////////////////////
    // stimulus helpers

    task automatic make_flit(input int dx, input int dy, input int src, output flit_t f);
        f.dst_x   = `ROUTER_COORD_W'(dx);
        f.dst_y   = `ROUTER_COORD_W'(dy);
        f.src_x   = `ROUTER_COORD_W'(src);
        f.src_y   = '0;
        f.tag     = `ROUTER_TAG_W'(next_tag);
        f.payload = $random(seed);
        next_tag  = (next_tag + 1) % 256;
        sent++;
    endtask

    task automatic stage_flit(input int port, input int dx, input int dy);
        flit_t f;
        make_flit(dx, dy, port, f);
        stage_in[port] = '{valid: 1'b1, flit: f};
    endtask

    task automatic stage_injection(input int port);
        flit_t f;
        make_flit($random(seed) & 7, $random(seed) & 7, port, f);
        stage_inj[port] = '{valid: 1'b1, flit: f};
    endtask

    // one clock edge, staged flits go out and the stage empties
    task automatic issue_cycle();
        @(posedge clk);
        for (int i = 0; i < NP; i++) begin
            link_in[i] <= stage_in[i];
            inject[i]  <= stage_inj[i];
            stage_in[i].valid  = 1'b0;
            stage_inj[i].valid = 1'b0;
        end
    endtask

    task automatic wait_drain(output bit ok);
        int n;
        n = 0;
        // pending lags the link strobes by two edges
        repeat (2) issue_cycle();
        while (pending != 0 && n < DRAIN_LIMIT) begin
            issue_cycle();
            n++;
        end
        ok = (pending == 0);
        // late duplicates would show up here
        repeat (3) issue_cycle();
    endtask

    task automatic note_timeout(input int num);
        $display("timeout: %0d flits never arrived in test %0d", pending, num);
        timed_out = 1'b1;
    endtask

    task automatic finish_test(input int num, input string name, input int base);
        int n;
        n = err_count + tb_errs - base;
        if (n == 0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, n);
        end
    endtask

    function automatic bit all_distinct(input int q [$]);
        bit [NP-1:0] seen;
        seen = '0;
        foreach (q[k]) begin
            if (seen[q[k]]) begin
                return 1'b0;
            end
            seen[q[k]] = 1'b1;
        end
        return 1'b1;
    endfunction

    //////////////////////////////////////////////////
    // test sequence

    initial begin
        bit ok;
        int base;
        int prev;
        int n;
        int len;
        int sent_rand;
        int first_src [$];
        seed      = 32'h8129;
        next_tag  = 0;
        sent      = 0;
        tb_errs   = 0;
        timed_out = 1'b0;
        sent_rand = 0;
        arst_n    = 1'b0;
        for (int i = 0; i < NP; i++) begin
            link_in[i]   = '0;
            inject[i]    = '0;
            stage_in[i]  = '0;
            stage_inj[i] = '0;
        end
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        // quiet outputs
        base = 0;
        for (int c = 0; c < 8; c++) begin
            issue_cycle();
            for (int i = 0; i < NP; i++) begin
                if (link_out[i].valid !== 1'b0 || eject[i].valid !== 1'b0) begin
                    $display("[FAIL] t=%0t: port %0d valid with no traffic", $time, i);
                    tb_errs++;
                end
            end
        end
        finish_test(1, "quiet after reset", base);

        // one flit at a time, every input to every direction
        base = err_count + tb_errs;
        for (int i = 0; i < NP && !timed_out; i++) begin
            for (int d = 0; d < 5 && !timed_out; d++) begin
                stage_flit(i, dest_x[d], dest_y[d]);
                issue_cycle();
                wait_drain(ok);
                if (!ok) begin
                    note_timeout(2);
                end
            end
        end
        finish_test(2, "single flit routing", base);

        // all inputs compete for xpos
        if (!timed_out) begin
            base = err_count + tb_errs;
            prev = delivered;
            for (int c = 0; c < 4; c++) begin
                for (int i = 0; i < NP; i++) begin
                    stage_flit(i, 6, 1);
                end
                issue_cycle();
            end
            n = 0;
            while (first_src.size() < 4 && n < DRAIN_LIMIT) begin
                issue_cycle();
                if (delivered != prev) begin
                    first_src.push_back(int'(last_src));
                    prev = delivered;
                end
                n++;
            end
            if (first_src.size() < 4) begin
                note_timeout(3);
            end else if (!all_distinct(first_src)) begin
                $display("[FAIL] t=%0t: first four grants not from four inputs: %p",
                         $time, first_src);
                tb_errs++;
            end
            if (!timed_out) begin
                wait_drain(ok);
                if (!ok) begin
                    note_timeout(3);
                end
            end
            finish_test(3, "round robin", base);
        end

        // inject on xpos while ypos flits wait for it
        if (!timed_out) begin
            base = err_count + tb_errs;
            stage_flit(1, 6, 3);
            issue_cycle();
            for (int c = 0; c < 2; c++) begin
                stage_flit(1, 6, 3);
                stage_injection(0);
                issue_cycle();
            end
            stage_injection(0);
            issue_cycle();
            wait_drain(ok);
            if (!ok) begin
                note_timeout(4);
            end
            finish_test(4, "inject override", base);
        end

        // random bursts, never more than a queue depth per port
        if (!timed_out) begin
            base = err_count + tb_errs;
            while (sent_rand < 200 && !timed_out) begin
                len = 1 + ($random(seed) & 7);
                for (int c = 0; c < len && sent_rand < 200; c++) begin
                    for (int i = 0; i < NP; i++) begin
                        if (($random(seed) & 1) && sent_rand < 200) begin
                            stage_flit(i, $random(seed) & 7, $random(seed) & 7);
                            sent_rand++;
                        end
                    end
                    issue_cycle();
                end
                wait_drain(ok);
                if (!ok) begin
                    note_timeout(5);
                end
            end
            finish_test(5, "random traffic", base);
        end

        $display("flits sent %0d, delivered %0d, errors %0d", sent, delivered,
                 err_count + tb_errs);
        if (timed_out || (err_count + tb_errs) != 0) begin
            $display("CHECKS FAILED");
        end else begin
            $display("ALL CHECKS PASSED");
        end
        $finish;
    end

endmodule
